// ==== hw/router_pkg.sv ====
`default_nettype none

package router_pkg;

    ////////////////////
    // header layout
    ////////////////////

    // padded ethernet + ipv4 + udp + sequence + vrt header
    localparam int HDR_WORDS = 13;
    localparam int HDR_IDX_W = 4;

    // first word handed to the dsp side, protocol headers stripped
    localparam logic [HDR_IDX_W-1:0] DSP_OFFSET = 4'd11;

    localparam int IDX_MAC_HI    = 0;
    localparam int IDX_MAC_LO    = 1;
    localparam int IDX_ETHERTYPE = 3;
    localparam int IDX_IP_PROTO  = 6;
    localparam int IDX_IP_DST    = 8;
    localparam int IDX_UDP_DST   = 9;

    // vrt header is the last buffered word
    localparam logic [HDR_IDX_W-1:0] IDX_VRT = 4'd12;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;

    ////////////////////
    // stream flags and settings
    ////////////////////

    localparam int FLAG_SOF = 0;
    localparam int FLAG_EOF = 1;

    localparam logic [7:0] SR_ADDR_IP    = 8'd1;
    localparam logic [7:0] SR_ADDR_PORTS = 8'd3;

    typedef struct packed {
        logic [3:0]  flags;
        logic [31:0] data;
    } stream_word_t;

    typedef struct packed {
        logic        stb;
        logic [7:0]  addr;
        logic [31:0] data;
    } set_bus_t;

    typedef struct packed {
        logic [31:0] ip_addr;
        logic [15:0] dsp_port;
    } router_cfg_t;

    typedef enum logic [1:0] {DEST_DSP, DEST_EXT, DEST_CPU} insp_dest_t;

    typedef enum logic [1:0] {ST_WAIT_SOF, ST_CAPTURE, ST_REPLAY, ST_LIVE} insp_state_t;

    typedef stream_word_t [HDR_WORDS-1:0] hdr_regs_t;

endpackage

`default_nettype wire

// ==== hw/router_settings.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_settings (
    input  logic                    stream_clk,
    input  logic                    reset_i,
    input  router_pkg::set_bus_t    set_i,
    output router_pkg::router_cfg_t cfg_o
);

    logic hit_ip;
    logic hit_ports;

    ////////////////////
    // address decode
    ////////////////////

    // a write lands only on the strobe cycle
    assign hit_ip    = set_i.stb & (set_i.addr == router_pkg::SR_ADDR_IP);
    assign hit_ports = set_i.stb & (set_i.addr == router_pkg::SR_ADDR_PORTS);

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge stream_clk) begin
        if (reset_i) begin
            cfg_o.ip_addr <= '0;
        end else if (hit_ip) begin
            cfg_o.ip_addr <= set_i.data;
        end
    end

    // upper half of the ports word held the second dsp port, unused here
    always_ff @(posedge stream_clk) begin
        if (reset_i) begin
            cfg_o.dsp_port <= '0;
        end else if (hit_ports) begin
            cfg_o.dsp_port <= set_i.data[15:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/frame_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_classifier (
    input  router_pkg::hdr_regs_t    hdr_i,
    input  router_pkg::stream_word_t last_i,
    input  router_pkg::router_cfg_t  cfg_i,
    output router_pkg::insp_dest_t   dest_o
);

    logic is_bcast;
    logic is_ip_udp;
    logic is_ip_match;
    logic is_dsp_port;
    logic is_vrt;
    logic is_short;

    ////////////////////
    // header fields
    ////////////////////

    assign is_bcast = (hdr_i[router_pkg::IDX_MAC_HI].data[15:0] == 16'hffff) &&
                      (hdr_i[router_pkg::IDX_MAC_LO].data == 32'hffff_ffff);

    assign is_ip_udp =
        (hdr_i[router_pkg::IDX_ETHERTYPE].data[15:0] == router_pkg::ETHERTYPE_IPV4) &&
        (hdr_i[router_pkg::IDX_IP_PROTO].data[23:16] == router_pkg::IP_PROTO_UDP);

    assign is_ip_match = (hdr_i[router_pkg::IDX_IP_DST].data == cfg_i.ip_addr);
    assign is_dsp_port = (hdr_i[router_pkg::IDX_UDP_DST].data[15:0] == cfg_i.dsp_port);

    // last word is still on the input bus, so vrt and eof come from it
    assign is_vrt   = (last_i.data[15:0] != 16'h0);
    assign is_short = last_i.flags[router_pkg::FLAG_EOF];

    ////////////////////
    // decision
    ////////////////////

    always_comb begin
        if (is_short || is_bcast) begin
            dest_o = router_pkg::DEST_CPU;
        end else if (!is_ip_udp) begin
            dest_o = router_pkg::DEST_CPU;
        end else if (!is_ip_match) begin
            dest_o = router_pkg::DEST_EXT;
        end else if (is_dsp_port && is_vrt) begin
            dest_o = router_pkg::DEST_DSP;
        end else begin
            dest_o = router_pkg::DEST_CPU;
        end
    end

endmodule

`default_nettype wire

// ==== hw/frame_inspector.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_inspector (
    input  logic                     stream_clk,
    input  logic                     reset_i,
    input  router_pkg::stream_word_t in_word_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  router_pkg::insp_dest_t   dest_i,
    output router_pkg::hdr_regs_t    hdr_o,
    output router_pkg::stream_word_t out_word_o,
    output logic                     dsp_valid_o,
    input  logic                     dsp_ready_i,
    output logic                     ext_valid_o,
    input  logic                     ext_ready_i,
    output logic                     cpu_valid_o,
    input  logic                     cpu_ready_i
);

    router_pkg::insp_state_t          state_q;
    router_pkg::insp_dest_t           dest_q;
    router_pkg::hdr_regs_t            hdr_q;
    logic [router_pkg::HDR_IDX_W-1:0] count_q;
    router_pkg::stream_word_t         replay_word;

    logic out_valid;
    logic out_ready;
    logic in_xfer;
    logic out_xfer;
    logic hdr_we;
    logic cnt_last;
    logic cap_end;
    logic dsp_first;

    ////////////////////
    // handshakes
    ////////////////////

    // ready of whichever output the frame was steered to
    always_comb begin
        case (dest_q)
            router_pkg::DEST_DSP: out_ready = dsp_ready_i;
            router_pkg::DEST_EXT: out_ready = ext_ready_i;
            default:              out_ready = cpu_ready_i;
        endcase
    end

    always_comb begin
        case (state_q)
            router_pkg::ST_WAIT_SOF: in_ready_o = 1'b1;
            router_pkg::ST_CAPTURE:  in_ready_o = 1'b1;
            router_pkg::ST_LIVE:     in_ready_o = out_ready;
            default:                 in_ready_o = 1'b0;
        endcase
    end

    assign in_xfer  = in_valid_i & in_ready_o;
    assign cnt_last = (count_q == router_pkg::IDX_VRT);

    // words ahead of a start of frame are swallowed without being stored
    assign hdr_we = in_xfer & ((state_q == router_pkg::ST_CAPTURE) |
                    ((state_q == router_pkg::ST_WAIT_SOF) &
                     in_word_i.flags[router_pkg::FLAG_SOF]));

    assign cap_end = hdr_we & (cnt_last | in_word_i.flags[router_pkg::FLAG_EOF]);

    ////////////////////
    // output word
    ////////////////////

    assign dsp_first = (dest_q == router_pkg::DEST_DSP) & (count_q == router_pkg::DSP_OFFSET);

    always_comb begin
        replay_word = hdr_q[count_q];
        // stripped frame needs its own start marker
        if (dsp_first) begin
            replay_word.flags = 4'b0001;
        end
    end

    assign out_word_o = (state_q == router_pkg::ST_REPLAY) ? replay_word : in_word_i;
    assign out_valid  = (state_q == router_pkg::ST_REPLAY) |
                        ((state_q == router_pkg::ST_LIVE) & in_valid_i);
    assign out_xfer   = out_valid & out_ready;

    assign dsp_valid_o = out_valid & (dest_q == router_pkg::DEST_DSP);
    assign ext_valid_o = out_valid & (dest_q == router_pkg::DEST_EXT);
    assign cpu_valid_o = out_valid & (dest_q == router_pkg::DEST_CPU);

    assign hdr_o = hdr_q;

    ////////////////////
    // header buffer and FSM
    ////////////////////

    always_ff @(posedge stream_clk) begin
        if (hdr_we) begin
            hdr_q[count_q] <= in_word_i;
        end
    end

    always_ff @(posedge stream_clk) begin
        if (reset_i) begin
            state_q <= router_pkg::ST_WAIT_SOF;
            dest_q  <= router_pkg::DEST_CPU;
            count_q <= '0;
        end else begin
            case (state_q)
                router_pkg::ST_WAIT_SOF, router_pkg::ST_CAPTURE: begin
                    if (cap_end) begin
                        state_q <= router_pkg::ST_REPLAY;
                        dest_q  <= dest_i;
                        count_q <= (dest_i == router_pkg::DEST_DSP) ? router_pkg::DSP_OFFSET : '0;
                    end else if (hdr_we) begin
                        state_q <= router_pkg::ST_CAPTURE;
                        count_q <= count_q + 1'b1;
                    end
                end
                router_pkg::ST_REPLAY: begin
                    if (out_xfer) begin
                        if (out_word_o.flags[router_pkg::FLAG_EOF]) begin
                            state_q <= router_pkg::ST_WAIT_SOF;
                            count_q <= '0;
                        end else if (cnt_last) begin
                            // rest of the frame streams straight through
                            state_q <= router_pkg::ST_LIVE;
                            count_q <= '0;
                        end else begin
                            count_q <= count_q + 1'b1;
                        end
                    end
                end
                router_pkg::ST_LIVE: begin
                    if (in_xfer & in_word_i.flags[router_pkg::FLAG_EOF]) begin
                        state_q <= router_pkg::ST_WAIT_SOF;
                    end
                end
                default: state_q <= router_pkg::ST_WAIT_SOF;
            endcase
        end
    end

    ////////////////////
    // checks
    ////////////////////

    a_valid_onehot: assert property (@(posedge stream_clk) disable iff (reset_i)
        $onehot0({dsp_valid_o, ext_valid_o, cpu_valid_o}));

    a_replay_stall: assert property (@(posedge stream_clk) disable iff (reset_i)
        (state_q == router_pkg::ST_REPLAY) |-> !in_ready_o);

    a_count_range: assert property (@(posedge stream_clk) disable iff (reset_i)
        count_q <= router_pkg::IDX_VRT);

endmodule

`default_nettype wire

// ==== hw/packet_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_router (
    input  logic                     stream_clk,
    input  logic                     reset_i,
    input  router_pkg::set_bus_t     set_i,
    input  router_pkg::stream_word_t inp_word_i,
    input  logic                     inp_valid_i,
    output logic                     inp_ready_o,
    output router_pkg::stream_word_t dsp_word_o,
    output router_pkg::stream_word_t ext_word_o,
    output router_pkg::stream_word_t cpu_word_o,
    output logic                     dsp_valid_o,
    output logic                     ext_valid_o,
    output logic                     cpu_valid_o,
    input  logic                     dsp_ready_i,
    input  logic                     ext_ready_i,
    input  logic                     cpu_ready_i
);

    router_pkg::router_cfg_t  cfg;
    router_pkg::insp_dest_t   dest;
    router_pkg::hdr_regs_t    hdr;
    router_pkg::stream_word_t out_word;

    router_settings u_settings (
        .stream_clk (stream_clk),
        .reset_i    (reset_i),
        .set_i      (set_i),
        .cfg_o      (cfg)
    );

    // the classifier sees the live input word as the last header word
    frame_classifier u_classifier (
        .hdr_i  (hdr),
        .last_i (inp_word_i),
        .cfg_i  (cfg),
        .dest_o (dest)
    );

    frame_inspector u_inspector (
        .stream_clk  (stream_clk),
        .reset_i     (reset_i),
        .in_word_i   (inp_word_i),
        .in_valid_i  (inp_valid_i),
        .in_ready_o  (inp_ready_o),
        .dest_i      (dest),
        .hdr_o       (hdr),
        .out_word_o  (out_word),
        .dsp_valid_o (dsp_valid_o),
        .dsp_ready_i (dsp_ready_i),
        .ext_valid_o (ext_valid_o),
        .ext_ready_i (ext_ready_i),
        .cpu_valid_o (cpu_valid_o),
        .cpu_ready_i (cpu_ready_i)
    );

    // one shared data bus, only the valids are steered
    assign dsp_word_o = out_word;
    assign ext_word_o = out_word;
    assign cpu_word_o = out_word;

endmodule

`default_nettype wire

// ==== test/router_tests.svh ====
////////////////////
// frame helpers
////////////////////

// padded ethernet, ipv4, udp, sequence and vrt words; flags[3:2] carry a pattern
task automatic build_frame(input int len, input logic [15:0] etype, input logic [31:0] ip,
                           input logic [15:0] port, input logic [15:0] vrt, input logic bcast);
    router_pkg::stream_word_t w;
    frame_q.delete();
    for (int i = 0; i < len; i++) begin
        w.flags = {i[1:0], (i == len - 1), (i == 0)};
        w.data  = {8'hc3, i[7:0], 16'(i * 40503)};
        case (i)
            router_pkg::IDX_MAC_HI:    w.data[15:0]  = bcast ? 16'hffff : 16'h0012;
            router_pkg::IDX_MAC_LO:    w.data        = bcast ? 32'hffff_ffff : 32'h3456_789a;
            router_pkg::IDX_ETHERTYPE: w.data[15:0]  = etype;
            router_pkg::IDX_IP_PROTO:  w.data[23:16] = router_pkg::IP_PROTO_UDP;
            router_pkg::IDX_IP_DST:    w.data        = ip;
            router_pkg::IDX_UDP_DST:   w.data[15:0]  = port;
            int'(router_pkg::IDX_VRT): w.data[15:0]  = vrt;
            default: ;
        endcase
        frame_q.push_back(w);
    end
endtask

task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(posedge stream_clk);
    set_i <= {1'b1, addr, data};
    @(posedge stream_clk);
    set_i <= '0;
endtask

// holds the word until the input handshake takes it
task automatic send_word(input router_pkg::stream_word_t w);
    logic ok;
    inp_word_i  <= w;
    inp_valid_i <= 1'b1;
    ok = 1'b0;
    while (!ok) begin
        @(negedge stream_clk);
        ok = inp_ready_o;
        @(posedge stream_clk);
    end
endtask

function automatic logic frame_done();
    return (dsp_q.size() > 0 && dsp_q[$].flags[router_pkg::FLAG_EOF]) ||
           (ext_q.size() > 0 && ext_q[$].flags[router_pkg::FLAG_EOF]) ||
           (cpu_q.size() > 0 && cpu_q[$].flags[router_pkg::FLAG_EOF]);
endfunction

task automatic check_frame(input string name, input router_pkg::insp_dest_t want);
    router_pkg::stream_word_t exp_q[$];
    router_pkg::stream_word_t got_q[$];
    router_pkg::stream_word_t w;
    int first;
    int stray;
    // dsp output drops the protocol headers
    first = (want == router_pkg::DEST_DSP) ? 11 : 0;
    for (int i = first; i < frame_q.size(); i++) begin
        w = frame_q[i];
        if (want == router_pkg::DEST_DSP && i == first) begin
            w.flags = 4'b0001;
        end
        exp_q.push_back(w);
    end
    case (want)
        router_pkg::DEST_DSP: got_q = dsp_q;
        router_pkg::DEST_EXT: got_q = ext_q;
        default:              got_q = cpu_q;
    endcase
    stray = dsp_q.size() + ext_q.size() + cpu_q.size() - got_q.size();
    checks++;
    if (got_q.size() != exp_q.size()) begin
        $display("[ERROR] %s: word count expected %0d actual %0d",
                 name, exp_q.size(), got_q.size());
        errors++;
    end
    if (stray != 0) begin
        $display("%s: %0d words came out on an output that was not chosen", name, stray);
        errors++;
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
        checks++;
        if (got_q[i] !== exp_q[i]) begin
            $display("[ERROR] %s: word %0d expected %h actual %h", name, i, exp_q[i], got_q[i]);
            errors++;
        end
    end
    dsp_q.delete();
    ext_q.delete();
    cpu_q.delete();
endtask

task automatic run_frame(input string name, input router_pkg::insp_dest_t want);
    int n;
    @(posedge stream_clk);
    foreach (frame_q[i]) begin
        send_word(frame_q[i]);
    end
    inp_valid_i <= 1'b0;
    n = 0;
    while (!frame_done() && n < 400) begin
        @(posedge stream_clk);
        n++;
    end
    if (!frame_done()) begin
        $display("%s: no end of frame came out within 400 cycles", name);
        errors++;
    end
    @(posedge stream_clk);
    check_frame(name, want);
endtask

////////////////////
// directed tests
////////////////////

task automatic test_dsp_path();
    write_setting(router_pkg::SR_ADDR_IP, 32'hc0a8_0a02);
    // upper half of the ports word is ignored
    write_setting(router_pkg::SR_ADDR_PORTS, 32'h7777_c351);
    build_frame(20, router_pkg::ETHERTYPE_IPV4, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
    run_frame("dsp_path", router_pkg::DEST_DSP);
endtask

task automatic test_ext_path();
    build_frame(20, router_pkg::ETHERTYPE_IPV4, 32'h0a00_0107, 16'hc351, 16'h1c01, 1'b0);
    run_frame("ext_path", router_pkg::DEST_EXT);
endtask

task automatic test_cpu_path();
    build_frame(20, 16'h86dd, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
    run_frame("cpu_not_ipv4", router_pkg::DEST_CPU);
    build_frame(18, router_pkg::ETHERTYPE_IPV4, 32'hc0a8_0a02, 16'hc351, 16'h0000, 1'b0);
    run_frame("cpu_zero_vrt", router_pkg::DEST_CPU);
    write_setting(8'd2, 32'h0a00_0001);
    write_setting(8'hff, 32'h0000_1234);
    build_frame(17, router_pkg::ETHERTYPE_IPV4, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
    run_frame("unused_addr", router_pkg::DEST_DSP);
endtask

task automatic test_bcast_short();
    build_frame(20, router_pkg::ETHERTYPE_IPV4, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b1);
    run_frame("broadcast", router_pkg::DEST_CPU);
    build_frame(6, router_pkg::ETHERTYPE_IPV4, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
    run_frame("short_frame", router_pkg::DEST_CPU);
endtask

task automatic test_framing();
    router_pkg::stream_word_t junk;
    router_pkg::insp_dest_t   want;
    @(posedge stream_clk);
    for (int i = 0; i < 3; i++) begin
        junk.flags = 4'b1000;
        junk.data  = 32'hbad0_0000 | i;
        send_word(junk);
    end
    inp_valid_i <= 1'b0;
    build_frame(16, router_pkg::ETHERTYPE_IPV4, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
    run_frame("before_sof", router_pkg::DEST_DSP);
    bp_en <= 1'b1;
    for (int k = 0; k < 8; k++) begin
        case (k % 4)
            0: begin
                build_frame(14 + k, 16'h0800, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
                want = router_pkg::DEST_DSP;
            end
            1: begin
                build_frame(14 + k, 16'h0800, 32'h0a00_0107, 16'hc351, 16'h1c01, 1'b0);
                want = router_pkg::DEST_EXT;
            end
            2: begin
                build_frame(14 + k, 16'h0806, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
                want = router_pkg::DEST_CPU;
            end
            default: begin
                build_frame(3 + k, 16'h0800, 32'hc0a8_0a02, 16'hc351, 16'h1c01, 1'b0);
                want = router_pkg::DEST_CPU;
            end
        endcase
        run_frame("bp_mixed", want);
    end
    bp_en <= 1'b0;
endtask

// ==== test/router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_tb;

    logic                     stream_clk;
    logic                     reset_i;
    router_pkg::set_bus_t     set_i;
    router_pkg::stream_word_t inp_word_i;
    logic                     inp_valid_i;
    logic                     inp_ready_o;
    router_pkg::stream_word_t dsp_word_o;
    router_pkg::stream_word_t ext_word_o;
    router_pkg::stream_word_t cpu_word_o;
    logic                     dsp_valid_o;
    logic                     ext_valid_o;
    logic                     cpu_valid_o;
    logic                     dsp_ready_i;
    logic                     ext_ready_i;
    logic                     cpu_ready_i;

    logic        bp_en;
    int          seed;
    logic [31:0] rnd;
    int          errors;
    int          checks;

    router_pkg::stream_word_t frame_q[$];
    router_pkg::stream_word_t dsp_q[$];
    router_pkg::stream_word_t ext_q[$];
    router_pkg::stream_word_t cpu_q[$];

    `include "router_tests.svh"

    packet_router DUT (.*);

    initial stream_clk = 1'b0;
    always #4 stream_clk = ~stream_clk;

    // random back-pressure on all three outputs when enabled
    always @(posedge stream_clk) begin
        if (bp_en) begin
            rnd = $random(seed);
            dsp_ready_i <= rnd[0];
            ext_ready_i <= rnd[1];
            cpu_ready_i <= rnd[2];
        end else begin
            dsp_ready_i <= 1'b1;
            ext_ready_i <= 1'b1;
            cpu_ready_i <= 1'b1;
        end
    end

    ////////////////////
    // output monitors
    ////////////////////

    // a word seen here is taken on the next rising edge
    always @(negedge stream_clk) begin
        if (!reset_i && dsp_valid_o && dsp_ready_i) begin
            dsp_q.push_back(dsp_word_o);
        end
    end

    always @(negedge stream_clk) begin
        if (!reset_i && ext_valid_o && ext_ready_i) begin
            ext_q.push_back(ext_word_o);
        end
    end

    always @(negedge stream_clk) begin
        if (!reset_i && cpu_valid_o && cpu_ready_i) begin
            cpu_q.push_back(cpu_word_o);
        end
    end

    initial begin
        seed        = 32'h3bcdfcab;
        errors      = 0;
        checks      = 0;
        bp_en       = 1'b0;
        reset_i     = 1'b1;
        set_i       = '0;
        inp_word_i  = '0;
        inp_valid_i = 1'b0;
        dsp_ready_i = 1'b1;
        ext_ready_i = 1'b1;
        cpu_ready_i = 1'b1;
        repeat (5) @(posedge stream_clk);
        reset_i <= 1'b0;
        @(negedge stream_clk);
        checks++;
        if (dsp_valid_o || ext_valid_o || cpu_valid_o || !inp_ready_o) begin
            $display("[ERROR] after_reset: valids and ready expected 0001 actual %b%b%b%b",
                     dsp_valid_o, ext_valid_o, cpu_valid_o, inp_ready_o);
            errors++;
        end
        test_dsp_path();
        test_ext_path();
        test_cpu_path();
        test_bcast_short();
        test_framing();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // about 20 frames of up to 30 cycles, doubled for back-pressure, with wide margin
    initial begin
        #20000;
        $display("watchdog: the run did not finish within 20000 ns");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+test
hw/router_pkg.sv
hw/router_settings.sv
hw/frame_classifier.sv
hw/frame_inspector.sv
hw/packet_router.sv
test/router_tb.sv

// ==== Makefile ====
TOP = router_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f tb.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
